// ==== verilog/bmem_pkg.sv ====
package bmem_pkg;

    // byte address on both sides of the controller
    typedef logic [31:0] addr_t;

    // one data beat on the burst memory bus
    typedef logic [63:0] beat_t;

    // one full cache line, four beats
    typedef logic [255:0] line_t;

    // beats moved per line transfer
    localparam int BEATS_PER_LINE = 4;

    // index of a beat inside its line
    typedef logic [1:0] beat_cnt_t;

    // byte offset bits inside a line, the line address sits above these
    localparam int LINE_OFFSET_BITS = 5;

    // arbiter states
    typedef enum logic [1:0] {
        scan,
        issue,
        wait_read,
        wait_write
    } arb_state_t;

endpackage

// ==== verilog/line_fill_unit.sv ====
`timescale 1ns/1ps

module line_fill_unit (
    input  logic            clk,
    input  logic            rst,

    input  logic            fill_start,
    input  bmem_pkg::addr_t fill_line_addr,

    input  bmem_pkg::addr_t bmem_raddr,
    input  bmem_pkg::beat_t bmem_rdata,
    input  logic            bmem_rvalid,

    output logic            fill_done,
    output bmem_pkg::line_t fill_line
);

    localparam int BEAT_W = $bits(bmem_pkg::beat_t);

    logic                armed;
    bmem_pkg::beat_cnt_t cnt;
    bmem_pkg::addr_t     expect_addr;
    bmem_pkg::beat_t     beats [bmem_pkg::BEATS_PER_LINE];

    logic            addr_match;
    logic            take_beat;
    logic            last_beat;
    bmem_pkg::line_t line_next;

    // compare line addresses only, offset bits ignored
    assign addr_match = bmem_raddr[31:bmem_pkg::LINE_OFFSET_BITS] ==
                        expect_addr[31:bmem_pkg::LINE_OFFSET_BITS];

    assign take_beat = armed && bmem_rvalid && addr_match;
    assign last_beat = cnt == bmem_pkg::beat_cnt_t'(bmem_pkg::BEATS_PER_LINE - 1);

    // line as it looks with the incoming beat dropped into its slot
    always_comb begin
        for (int i = 0; i < bmem_pkg::BEATS_PER_LINE; i++) begin
            if (bmem_pkg::beat_cnt_t'(i) == cnt) begin
                line_next[i*BEAT_W +: BEAT_W] = bmem_rdata;
            end else begin
                line_next[i*BEAT_W +: BEAT_W] = beats[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            armed     <= 1'b0;
            cnt       <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (fill_start) begin
                armed <= 1'b1;
                cnt   <= '0;
            end else if (take_beat) begin
                cnt <= cnt + 1'b1;
                if (last_beat) begin
                    armed     <= 1'b0;
                    fill_done <= 1'b1;
                end
            end
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        if (fill_start) begin
            expect_addr <= fill_line_addr;
        end
        if (take_beat) begin
            beats[cnt] <= bmem_rdata;
            if (last_beat) begin
                fill_line <= line_next;
            end
        end
    end

endmodule

// ==== verilog/write_beat_unit.sv ====
`timescale 1ns/1ps

module write_beat_unit (
    input  logic            clk,
    input  logic            rst,

    input  logic            wr_start,
    input  bmem_pkg::line_t wr_line,

    output logic            bmem_write,
    output bmem_pkg::beat_t bmem_wdata,
    output logic            wr_done
);

    localparam int BEAT_W = $bits(bmem_pkg::beat_t);

    logic                active;
    bmem_pkg::beat_cnt_t cnt;
    bmem_pkg::line_t     line_q;

    logic last_beat;

    assign last_beat = cnt == bmem_pkg::beat_cnt_t'(bmem_pkg::BEATS_PER_LINE - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            cnt     <= '0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (wr_start) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 1'b1;
                // done follows the final beat by one cycle
                if (last_beat) begin
                    active  <= 1'b0;
                    wr_done <= 1'b1;
                end
            end
        end
    end

    // line shifts down one beat per cycle, lowest beat first
    always_ff @(posedge clk) begin
        if (wr_start) begin
            line_q <= wr_line;
        end else if (active) begin
            line_q <= line_q >> BEAT_W;
        end
    end

    assign bmem_write = active;
    assign bmem_wdata = line_q[BEAT_W-1:0];

endmodule

// ==== verilog/bmem_arbiter.sv ====
`timescale 1ns/1ps

module bmem_arbiter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // miss ports
    input  logic            [NUM_PORTS-1:0]       req_read,
    input  logic            [NUM_PORTS-1:0]       req_write,
    input  bmem_pkg::addr_t [NUM_PORTS-1:0]       req_addr,
    input  bmem_pkg::line_t [NUM_PORTS-1:0]       req_wdata,
    output logic            [NUM_PORTS-1:0]       resp,
    output bmem_pkg::line_t                       rdata,

    // burst memory command side
    input  logic                                  bmem_ready,
    output bmem_pkg::addr_t                       bmem_addr,
    output logic                                  bmem_read,

    // line-fill unit
    output logic                                  fill_start,
    output bmem_pkg::addr_t                       fill_line_addr,
    input  logic                                  fill_done,
    input  bmem_pkg::line_t                       fill_line,

    // write-beat unit
    output logic                                  wr_start,
    output bmem_pkg::line_t                       wr_line,
    input  logic                                  wr_done
);

    localparam int PTR_W = $clog2(NUM_PORTS);

    bmem_pkg::arb_state_t state;
    logic [PTR_W-1:0]     ptr;
    logic [PTR_W-1:0]     owner;

    bmem_pkg::addr_t owner_line_addr;
    logic            owner_read;
    logic            launch;
    logic            done_hit;

    // next port in round-robin order, wrapping at the last one
    function automatic logic [PTR_W-1:0] next_port(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(NUM_PORTS - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // owner address aligned down to its line
    always_comb begin
        owner_line_addr = req_addr[owner];
        owner_line_addr[bmem_pkg::LINE_OFFSET_BITS-1:0] = '0;
    end

    assign owner_read = req_read[owner];

    // command leaves only when memory can take it
    assign launch = (state == bmem_pkg::issue) && bmem_ready;

    assign done_hit = ((state == bmem_pkg::wait_read) && fill_done) ||
                      ((state == bmem_pkg::wait_write) && wr_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bmem_pkg::scan;
            ptr   <= '0;
            owner <= '0;
        end else begin
            case (state)
                bmem_pkg::scan: begin
                    // one port looked at per cycle
                    if (req_read[ptr] || req_write[ptr]) begin
                        owner <= ptr;
                        state <= bmem_pkg::issue;
                    end else begin
                        ptr <= next_port(ptr);
                    end
                end
                bmem_pkg::issue: begin
                    if (bmem_ready) begin
                        state <= owner_read ? bmem_pkg::wait_read : bmem_pkg::wait_write;
                    end
                end
                bmem_pkg::wait_read, bmem_pkg::wait_write: begin
                    if (done_hit) begin
                        state <= bmem_pkg::scan;
                        ptr   <= next_port(owner);
                    end
                end
                default: begin
                    state <= bmem_pkg::scan;
                end
            endcase
        end
    end

    // read command is a single-cycle pulse out of issue
    assign bmem_read  = launch && owner_read;
    assign bmem_addr  = owner_line_addr;

    assign fill_start     = launch && owner_read;
    assign fill_line_addr = owner_line_addr;

    assign wr_start = launch && !owner_read;
    assign wr_line  = req_wdata[owner];

    // completion goes back to the owner only
    assign resp  = done_hit ? (NUM_PORTS'(1) << owner) : '0;
    assign rdata = fill_line;

endmodule

// ==== verilog/bmem_ctrl_top.sv ====
`timescale 1ns/1ps

module bmem_ctrl_top #(
    parameter int NUM_PORTS = 4
) (
    input  logic                            clk,
    input  logic                            rst,

    // miss ports
    input  logic            [NUM_PORTS-1:0] req_read,
    input  logic            [NUM_PORTS-1:0] req_write,
    input  bmem_pkg::addr_t [NUM_PORTS-1:0] req_addr,
    input  bmem_pkg::line_t [NUM_PORTS-1:0] req_wdata,
    output logic            [NUM_PORTS-1:0] resp,
    output bmem_pkg::line_t                 rdata,

    // burst memory
    output bmem_pkg::addr_t                 bmem_addr,
    output logic                            bmem_read,
    output logic                            bmem_write,
    output bmem_pkg::beat_t                 bmem_wdata,
    input  logic                            bmem_ready,
    input  bmem_pkg::addr_t                 bmem_raddr,
    input  bmem_pkg::beat_t                 bmem_rdata,
    input  logic                            bmem_rvalid
);

    logic            fill_start;
    bmem_pkg::addr_t fill_line_addr;
    logic            fill_done;
    bmem_pkg::line_t fill_line;

    logic            wr_start;
    bmem_pkg::line_t wr_line;
    logic            wr_done;

    bmem_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .req_read       (req_read),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .resp           (resp),
        .rdata          (rdata),
        .bmem_ready     (bmem_ready),
        .bmem_addr      (bmem_addr),
        .bmem_read      (bmem_read),
        .fill_start     (fill_start),
        .fill_line_addr (fill_line_addr),
        .fill_done      (fill_done),
        .fill_line      (fill_line),
        .wr_start       (wr_start),
        .wr_line        (wr_line),
        .wr_done        (wr_done)
    );

    // read beats come back into here
    line_fill_unit u_fill (
        .clk            (clk),
        .rst            (rst),
        .fill_start     (fill_start),
        .fill_line_addr (fill_line_addr),
        .bmem_raddr     (bmem_raddr),
        .bmem_rdata     (bmem_rdata),
        .bmem_rvalid    (bmem_rvalid),
        .fill_done      (fill_done),
        .fill_line      (fill_line)
    );

    // write-back beats go out from here
    write_beat_unit u_write (
        .clk        (clk),
        .rst        (rst),
        .wr_start   (wr_start),
        .wr_line    (wr_line),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .wr_done    (wr_done)
    );

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over two rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/bmem_ctrl_props.sv ====
`timescale 1ns/1ps

module bmem_ctrl_props #(
    parameter int NUM_PORTS = 4
) (
    input logic                            clk,
    input logic                            rst,
    input logic            [NUM_PORTS-1:0] req_read,
    input logic            [NUM_PORTS-1:0] req_write,
    input bmem_pkg::addr_t [NUM_PORTS-1:0] req_addr,
    input bmem_pkg::line_t [NUM_PORTS-1:0] req_wdata,
    input logic            [NUM_PORTS-1:0] resp,
    input bmem_pkg::line_t                 rdata,
    input bmem_pkg::addr_t                 bmem_addr,
    input logic                            bmem_read,
    input logic                            bmem_write,
    input bmem_pkg::beat_t                 bmem_wdata,
    input logic                            bmem_ready
);

    localparam int PTR_W = $clog2(NUM_PORTS);

    int err_cnt = 0;

    logic [NUM_PORTS-1:0] req_any;
    logic [NUM_PORTS-1:0] held;
    logic [NUM_PORTS-1:0] skipped;
    logic [PTR_W-1:0]     resp_idx;
    logic [PTR_W-1:0]     prev_owner;
    int                   own_dist;
    logic                 busy;
    bmem_pkg::addr_t      resp_line_addr;
    bmem_pkg::line_t      exp_rdata;
    bmem_pkg::line_t      wr_beats;

    // beat k of line L holds {L, k} twice
    function automatic bmem_pkg::line_t read_pattern(input bmem_pkg::addr_t a);
        bmem_pkg::line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*64 +: 64] = {2{a[31:5], 5'(k)}};
        end
        return l;
    endfunction

    always_comb begin
        req_any  = req_read | req_write;
        resp_idx = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (resp[i]) begin
                resp_idx = PTR_W'(i);
            end
        end
        resp_line_addr = req_addr[resp_idx];
        resp_line_addr[bmem_pkg::LINE_OFFSET_BITS-1:0] = '0;
        exp_rdata = read_pattern(resp_line_addr);
        // ports strictly between the previous owner and this one
        own_dist = (int'(resp_idx) - int'(prev_owner) + NUM_PORTS) % NUM_PORTS;
        if (own_dist == 0) begin
            own_dist = NUM_PORTS;
        end
        for (int j = 0; j < NUM_PORTS; j++) begin
            skipped[j] = ((j - int'(prev_owner) + NUM_PORTS) % NUM_PORTS < own_dist) &&
                         (j != int'(prev_owner));
        end
    end

    // held marks ports requesting without a break since the last resp
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_owner <= PTR_W'(NUM_PORTS - 1);
            held       <= '1;
            busy       <= 1'b0;
        end else if (resp != '0) begin
            prev_owner <= resp_idx;
            held       <= req_any & ~resp;
            busy       <= 1'b0;
        end else begin
            held <= held & req_any;
            if (bmem_read || bmem_write) begin
                busy <= 1'b1;
            end
        end
    end

    // last four beats with the oldest in the low slice
    always_ff @(posedge clk) begin
        wr_beats <= {bmem_wdata, wr_beats[255:64]};
    end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        (resp & req_read) != '0 |-> rdata == exp_rdata)
        else begin
            $error("ERROR %0t rdata expected %h actual %h",
                   $time, $sampled(exp_rdata), $sampled(rdata));
            err_cnt++;
        end

    a_write_data: assert property (@(posedge clk) disable iff (rst)
        $fell(bmem_write) |-> wr_beats == req_wdata[resp_idx])
        else begin
            $error("ERROR %0t bmem_wdata expected %h actual %h",
                   $time, $sampled(req_wdata[resp_idx]), $sampled(wr_beats));
            err_cnt++;
        end

    a_write_shape: assert property (@(posedge clk) disable iff (rst)
        $fell(bmem_write) |-> (resp & req_write) != '0 && $past(bmem_write, 2) &&
            $past(bmem_write, 3) && $past(bmem_write, 4) && !$past(bmem_write, 5))
        else begin
            $error("write burst was not four beats long with resp right after it");
            err_cnt++;
        end

    a_write_addr: assert property (@(posedge clk) disable iff (rst)
        $fell(bmem_write) |-> bmem_addr == resp_line_addr)
        else begin
            $error("ERROR %0t bmem_addr expected %h actual %h",
                   $time, $sampled(resp_line_addr), $sampled(bmem_addr));
            err_cnt++;
        end

    a_write_hold: assert property (@(posedge clk) disable iff (rst)
        bmem_write && $past(bmem_write) |-> $stable(bmem_addr))
        else begin
            $error("bmem_addr moved in the middle of a write burst");
            err_cnt++;
        end

    a_read_pulse: assert property (@(posedge clk) disable iff (rst)
        bmem_read |=> !bmem_read)
        else begin
            $error("bmem_read stayed high for two cycles");
            err_cnt++;
        end

    a_cmd_legal: assert property (@(posedge clk) disable iff (rst)
        (bmem_read || $rose(bmem_write)) |-> !busy && !(bmem_read && bmem_write) &&
            (bmem_read ? bmem_ready : $past(bmem_ready)))
        else begin
            $error("command started while busy, overlapping, or with bmem_ready low");
            err_cnt++;
        end

    a_round_robin: assert property (@(posedge clk) disable iff (rst)
        resp != '0 |-> (skipped & held & req_any) == '0)
        else begin
            $error("resp went to port %0d while a port ahead of it kept waiting",
                   $sampled(resp_idx));
            err_cnt++;
        end

    a_resp_legal: assert property (@(posedge clk) disable iff (rst)
        $onehot0(resp) && (resp & ~req_any) == '0)
        else begin
            $error("resp was not one-hot or went to a port with no request");
            err_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !bmem_read && !bmem_write && resp == '0)
        else begin
            $error("outputs were not idle right after reset");
            err_cnt++;
        end

endmodule

// ==== dv/tb_bmem_ctrl.sv ====
`timescale 1ns/1ps

module tb_bmem_ctrl;

    localparam int NUM_PORTS       = 4;
    localparam int RAND_REQS       = 8;
    localparam int TOTAL_REQS      = NUM_PORTS * (RAND_REQS + 2);
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 40 + 200;

    logic clk;
    logic rst;

    logic            [NUM_PORTS-1:0] req_read;
    logic            [NUM_PORTS-1:0] req_write;
    bmem_pkg::addr_t [NUM_PORTS-1:0] req_addr;
    bmem_pkg::line_t [NUM_PORTS-1:0] req_wdata;
    logic            [NUM_PORTS-1:0] resp;
    bmem_pkg::line_t                 rdata;
    bmem_pkg::addr_t                 bmem_addr;
    logic                            bmem_read;
    logic                            bmem_write;
    bmem_pkg::beat_t                 bmem_wdata;
    logic                            bmem_ready;
    bmem_pkg::addr_t                 bmem_raddr;
    bmem_pkg::beat_t                 bmem_rdata;
    logic                            bmem_rvalid;

    // memory model state
    bmem_pkg::addr_t pend_addr[$];
    int              beat_k;
    int              gap;
    int              ready_left;

    // one LCG stream per process, the last one is the memory model's
    int unsigned rng [NUM_PORTS+1];

    clk_gen u_clk (.clk(clk), .rst(rst));

    bmem_ctrl_top #(.NUM_PORTS(NUM_PORTS)) UUT (.*);

    bind bmem_ctrl_top bmem_ctrl_props #(.NUM_PORTS(NUM_PORTS)) u_props (.*);

    function automatic int unsigned next_rand(input int idx);
        rng[idx] = rng[idx] * 32'd1664525 + 32'd1013904223;
        return rng[idx];
    endfunction

    // upper bits only, the low ones repeat quickly
    function automatic int pick(input int idx, input int n);
        return int'((next_rand(idx) >> 16) % n);
    endfunction

    function automatic bmem_pkg::line_t rand_line(input int idx);
        bmem_pkg::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = next_rand(idx);
        end
        return l;
    endfunction

    function automatic bmem_pkg::beat_t beat_pattern(input bmem_pkg::addr_t a, input int k);
        return {2{a[31:5], 5'(k)}};
    endfunction

    // hold the request until resp, drop it on the next falling edge
    task automatic run_request(input int p, input bit is_read,
                               input bmem_pkg::addr_t a, input bmem_pkg::line_t d);
        @(negedge clk);
        req_read[p]  = is_read;
        req_write[p] = !is_read;
        req_addr[p]  = a;
        req_wdata[p] = d;
        do begin
            @(posedge clk);
        end while (!resp[p]);
        @(negedge clk);
        req_read[p]  = 1'b0;
        req_write[p] = 1'b0;
    endtask

    task automatic all_ports_at_once(input bit is_read);
        for (int p = 0; p < NUM_PORTS; p++) begin
            fork
                automatic int pp = p;
                run_request(pp, is_read, next_rand(pp), rand_line(pp));
            join_none
        end
        wait fork;
    endtask

    task automatic port_traffic(input int p);
        for (int n = 0; n < RAND_REQS; n++) begin
            repeat (pick(p, 4)) @(negedge clk);
            run_request(p, pick(p, 2) == 0, next_rand(p), rand_line(p));
        end
    endtask

    // read commands queue up for the beat generator
    always @(posedge clk) begin
        if (!rst && bmem_read) begin
            pend_addr.push_back(bmem_addr);
        end
    end

    always @(negedge clk) begin
        bmem_rvalid = 1'b0;
        if (!rst) begin
            if (gap > 0) begin
                gap--;
            end else if (pend_addr.size() != 0) begin
                bmem_raddr  = pend_addr[0];
                bmem_rdata  = beat_pattern(pend_addr[0], beat_k);
                bmem_rvalid = 1'b1;
                gap         = pick(NUM_PORTS, 3);
                beat_k++;
                if (beat_k == bmem_pkg::BEATS_PER_LINE) begin
                    beat_k = 0;
                    void'(pend_addr.pop_front());
                end
            end
            // back-pressure stretches
            if (ready_left > 0) begin
                ready_left--;
            end else begin
                bmem_ready = !bmem_ready;
                ready_left = bmem_ready ? pick(NUM_PORTS, 6) + 2 : pick(NUM_PORTS, 4);
            end
        end
    end

    always @(negedge clk) begin
        if (UUT.u_props.err_cnt != 0) begin
            $display("TEST FAIL");
            $fatal(1, "an assertion on the controller failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("TEST FAIL");
        $fatal(1, "timeout, not all requests received their response");
    end

    initial begin
        req_read    = '0;
        req_write   = '0;
        req_addr    = '0;
        req_wdata   = '0;
        bmem_ready  = 1'b1;
        bmem_raddr  = '0;
        bmem_rdata  = '0;
        bmem_rvalid = 1'b0;
        beat_k      = 0;
        gap         = 0;
        ready_left  = 3;
        rng[0]      = 32'd22591;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            rng[i] = rng[i-1] * 32'd1664525 + 32'd1013904223;
        end
        wait (rst == 1'b0);
        // every port at once, reads first, then write-backs
        all_ports_at_once(1'b1);
        all_ports_at_once(1'b0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            fork
                automatic int pp = p;
                port_traffic(pp);
            join_none
        end
        wait fork;
        repeat (2) @(negedge clk);
        if (UUT.u_props.err_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "assertion failures were seen during the run");
        end
    end

endmodule

// ==== src.f ====
verilog/bmem_pkg.sv
verilog/line_fill_unit.sv
verilog/write_beat_unit.sv
verilog/bmem_arbiter.sv
verilog/bmem_ctrl_top.sv
dv/clk_gen.sv
dv/bmem_ctrl_props.sv
dv/tb_bmem_ctrl.sv
